//--- files.f
logic/conv_pkg.sv
logic/conv_ifs.sv
logic/layer_ctrl.sv
logic/input_store.sv
logic/kernel_mac.sv
logic/channel_accum.sv
logic/conv_layer_top.sv
verif/conv_layer_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the convolution layer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module conv_layer_tb -f files.f -o conv_layer_sim
./obj_dir/conv_layer_sim

//--- verif/conv_layer_tb.sv
`default_nettype none

module conv_layer_tb;
	import conv_pkg::*;

	localparam int IMG_W        = 6;
	localparam int IMG_H        = 5;
	localparam int CIN          = 3;
	localparam int COUT         = 2;
	localparam int PERIOD       = 4;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_POS      = IMG_H * IMG_W;
	localparam int NUM_OUT      = COUT * NUM_POS;

	////////////////////
	// Cycle budget
	////////////////////

	localparam int WEIGHT_CYCLES = COUT * CIN * TAPS + 2;
	localparam int IMAGE_CYCLES  = CIN * NUM_POS + 2;
	// Image end to final result, plus slack for busy to settle
	localparam int LAYER_CYCLES  = COUT * NUM_POS * CIN * TAPS + 3 + 16;
	localparam int IDLE_CYCLES   = 20;
	localparam int BUDGET = RESET_CYCLES + IDLE_CYCLES
		+ 3 * (WEIGHT_CYCLES + IMAGE_CYCLES + LAYER_CYCLES)
		+ (IMAGE_CYCLES + LAYER_CYCLES + 12) + 200;

	logic    clk;
	logic    reset;
	logic    valid_in;
	pixel_t  pxl_in;
	logic    valid_weight_in;
	weight_t weight_in;
	acc_t    pxl_out;
	logic    valid_out;
	logic    busy;

	int          img [CIN][IMG_H][IMG_W];
	int          wts [COUT][CIN][TAPS];
	int          outq [$];
	logic        busy_at_last_out;
	logic [15:0] lfsr;

	conv_layer_top #(
		.IMAGE_WIDTH    (IMG_W),
		.IMAGE_HEIGHT   (IMG_H),
		.CHANNEL_NUM_IN (CIN),
		.CHANNEL_NUM_OUT(COUT)
	) u_dut (
		.clk            (clk),
		.reset          (reset),
		.valid_in       (valid_in),
		.pxl_in         (pxl_in),
		.valid_weight_in(valid_weight_in),
		.weight_in      (weight_in),
		.pxl_out        (pxl_out),
		.valid_out      (valid_out),
		.busy           (busy)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Results are sampled away from the active edge
	always @(negedge clk) begin
		if (valid_out) begin
			outq.push_back(int'(pxl_out));
			busy_at_last_out = busy;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (actual !== expected)
			stop_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	// 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return v;
	endfunction

	function automatic int rand_signed8();
		logic [7:0] b;
		b = 8'(rand_bits(8));
		return int'($signed(b));
	endfunction

	// Zero-padded 3x3 window summed over all input channels
	function automatic int ref_model(input int oc, input int r, input int c);
		int sum;
		int ic;
		int t;
		int rr;
		int cc;
		sum = 0;
		for (ic = 0; ic < CIN; ic++) begin
			for (t = 0; t < TAPS; t++) begin
				rr = r + t / 3 - 1;
				cc = c + t % 3 - 1;
				if (rr >= 0 && rr < IMG_H && cc >= 0 && cc < IMG_W)
					sum += img[ic][rr][cc] * wts[oc][ic][t];
			end
		end
		return sum;
	endfunction

	task automatic fill_random_image();
		int ic;
		int r;
		int c;
		for (ic = 0; ic < CIN; ic++)
			for (r = 0; r < IMG_H; r++)
				for (c = 0; c < IMG_W; c++)
					img[ic][r][c] = rand_signed8();
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// Order is output channel, input channel, then row-major taps
	task automatic load_weights();
		int oc;
		int ic;
		int t;
		for (oc = 0; oc < COUT; oc++) begin
			for (ic = 0; ic < CIN; ic++) begin
				for (t = 0; t < TAPS; t++) begin
					@(posedge clk);
					valid_weight_in <= 1'b1;
					weight_in       <= weight_t'(wts[oc][ic][t]);
				end
			end
		end
		@(posedge clk);
		valid_weight_in <= 1'b0;
	endtask

	task automatic send_image();
		int ic;
		int r;
		int c;
		for (ic = 0; ic < CIN; ic++) begin
			for (r = 0; r < IMG_H; r++) begin
				for (c = 0; c < IMG_W; c++) begin
					@(posedge clk);
					valid_in <= 1'b1;
					pxl_in   <= pixel_t'(img[ic][r][c]);
				end
			end
		end
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	// Stream the image, then wait for the layer to finish
	task automatic run_image(input string name);
		int n;
		outq.delete();
		send_image();
		n = 0;
		@(negedge clk);
		while (!busy && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!busy)
			stop_run($sformatf("%s: busy did not rise after the image was loaded", name));
		while (busy)
			@(negedge clk);
		check({name, " count"}, NUM_OUT, outq.size());
	endtask

	task automatic compare_with_model(input string name);
		int k;
		int p;
		for (k = 0; k < NUM_OUT; k++) begin
			p = k % NUM_POS;
			check(name, ref_model(k / NUM_POS, p / IMG_W, p % IMG_W), outq[k]);
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic reset_state();
		int i;
		for (i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge clk);
			check("reset_state busy", 0, busy);
			check("reset_state valid_out", 0, valid_out);
		end
		check("reset_state outputs", 0, outq.size());
	endtask

	task automatic center_tap();
		int oc;
		int ic;
		int t;
		int k;
		int p;
		int exp;
		for (oc = 0; oc < COUT; oc++)
			for (ic = 0; ic < CIN; ic++)
				for (t = 0; t < TAPS; t++)
					wts[oc][ic][t] = (t == 4) ? 1 : 0;
		fill_random_image();
		load_weights();
		run_image("center_tap");
		// Random pixels make each raster position distinct
		for (k = 0; k < NUM_OUT; k++) begin
			p = k % NUM_POS;
			exp = 0;
			for (ic = 0; ic < CIN; ic++)
				exp += img[ic][p / IMG_W][p % IMG_W];
			check("center_tap", exp, outq[k]);
		end
	endtask

	task automatic border_padding();
		int oc;
		int ic;
		int t;
		int r;
		int c;
		int k;
		int rows_in;
		int cols_in;
		for (oc = 0; oc < COUT; oc++)
			for (ic = 0; ic < CIN; ic++)
				for (t = 0; t < TAPS; t++)
					wts[oc][ic][t] = 1;
		for (ic = 0; ic < CIN; ic++)
			for (r = 0; r < IMG_H; r++)
				for (c = 0; c < IMG_W; c++)
					img[ic][r][c] = 1;
		load_weights();
		run_image("border_padding");
		for (k = 0; k < NUM_OUT; k++) begin
			r = (k % NUM_POS) / IMG_W;
			c = (k % NUM_POS) % IMG_W;
			rows_in = (r == 0 || r == IMG_H - 1) ? 2 : 3;
			cols_in = (c == 0 || c == IMG_W - 1) ? 2 : 3;
			check("border_padding", rows_in * cols_in * CIN, outq[k]);
		end
	endtask

	task automatic random_layer();
		int oc;
		int ic;
		int t;
		for (oc = 0; oc < COUT; oc++)
			for (ic = 0; ic < CIN; ic++)
				for (t = 0; t < TAPS; t++)
					wts[oc][ic][t] = rand_signed8();
		fill_random_image();
		load_weights();
		run_image("random_layer");
		compare_with_model("random_layer");
	endtask

	// Weights from random_layer stay in the DUT
	task automatic weight_reuse();
		fill_random_image();
		run_image("weight_reuse");
		compare_with_model("weight_reuse");
		check("weight_reuse busy at last output", 1, busy_at_last_out);
		repeat (10) @(negedge clk);
		check("weight_reuse late outputs", NUM_OUT, outq.size());
		check("weight_reuse busy", 0, busy);
	endtask

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		valid_in        = 1'b0;
		pxl_in          = '0;
		valid_weight_in = 1'b0;
		weight_in       = '0;
		lfsr            = 16'd58;
		busy_at_last_out = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		reset_state();
		center_tap();
		border_padding();
		random_layer();
		weight_reuse();
		$display("Simulation finished: PASS");
		$finish;
	end

	// Watchdog
	initial begin
		#(PERIOD * BUDGET);
		stop_run("Timeout: the tests did not finish within the cycle budget");
	end

endmodule

`default_nettype wire

//--- logic/conv_layer_top.sv
`default_nettype none

module conv_layer_top #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  conv_pkg::pixel_t  pxl_in,
	input  logic             valid_weight_in,
	input  conv_pkg::weight_t weight_in,
	output conv_pkg::acc_t    pxl_out,
	output logic             valid_out,
	output logic             busy
);
	import conv_pkg::*;

	logic   image_loaded;
	pixel_t pxl_rd;

	tap_if #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.IMAGE_HEIGHT   (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) u_taps ();

	conv_if #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.IMAGE_HEIGHT   (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) u_conv ();

	////////////////////
	// Sweep and datapath
	////////////////////

	layer_ctrl #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.IMAGE_HEIGHT   (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.image_loaded(image_loaded),
		.busy        (busy),
		.taps        (u_taps.ctrl)
	);

	input_store #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.IMAGE_HEIGHT   (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) u_store (
		.clk         (clk),
		.reset       (reset),
		.valid_in    (valid_in),
		.pxl_in      (pxl_in),
		.image_loaded(image_loaded),
		.pxl_rd      (pxl_rd),
		.taps        (u_taps.store)
	);

	kernel_mac #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.IMAGE_HEIGHT   (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) u_mac (
		.clk            (clk),
		.reset          (reset),
		.valid_weight_in(valid_weight_in),
		.weight_in      (weight_in),
		.pxl_rd         (pxl_rd),
		.taps           (u_taps.mac),
		.conv           (u_conv.mac)
	);

	channel_accum #(
		.IMAGE_WIDTH    (IMAGE_WIDTH),
		.IMAGE_HEIGHT   (IMAGE_HEIGHT),
		.CHANNEL_NUM_IN (CHANNEL_NUM_IN),
		.CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
	) u_accum (
		.clk      (clk),
		.reset    (reset),
		.conv     (u_conv.accum),
		.pxl_out  (pxl_out),
		.valid_out(valid_out)
	);

endmodule

`default_nettype wire

//--- logic/channel_accum.sv
`default_nettype none

module channel_accum #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
) (
	input  logic          clk,
	input  logic          reset,
	conv_if.accum         conv,
	output conv_pkg::acc_t pxl_out,
	output logic          valid_out
);
	import conv_pkg::*;

	localparam int DEPTH = IMAGE_HEIGHT * IMAGE_WIDTH;

	acc_t psum [DEPTH];
	acc_t total;

	// First channel starts a fresh sum at this position
	assign total = conv.first_ch ? conv.sum : psum[conv.pos] + conv.sum;

	////////////////////
	// Partial sums
	////////////////////

	always_ff @(posedge clk) begin
		if (conv.valid)
			psum[conv.pos] <= total;
	end

	////////////////////
	// Result output
	////////////////////

	// Output channels finish one at a time, so results leave in raster order
	always_ff @(posedge clk) begin
		if (conv.valid && conv.last_ch)
			pxl_out <= total;
	end

	always_ff @(posedge clk) begin
		if (reset)
			valid_out <= 1'b0;
		else
			valid_out <= conv.valid && conv.last_ch;
	end

endmodule

`default_nettype wire

//--- logic/kernel_mac.sv
`default_nettype none

module kernel_mac #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_weight_in,
	input  conv_pkg::weight_t weight_in,
	input  conv_pkg::pixel_t  pxl_rd,
	tap_if.mac               taps,
	conv_if.mac              conv
);
	import conv_pkg::*;

	localparam int W_DEPTH = CHANNEL_NUM_OUT * CHANNEL_NUM_IN * TAPS;
	localparam int W_AW    = $clog2(W_DEPTH);
	localparam int POS_AW  = $clog2(IMAGE_HEIGHT * IMAGE_WIDTH);

	weight_t           wmem [W_DEPTH];
	logic [W_AW-1:0]   w_cnt;
	logic              w_wr;
	weight_t           w_rd;
	logic              d_valid;
	logic              d_last_tap, d_first_ch, d_last_ch;
	logic [POS_AW-1:0] d_pos;
	prod_t             prod;
	acc_t              acc;
	logic              acc_clear;

	////////////////////
	// Weight load
	////////////////////

	// Held off while taps are being issued
	assign w_wr = valid_weight_in && !taps.valid;

	always_ff @(posedge clk) begin
		if (w_wr)
			wmem[w_cnt] <= weight_in;
	end

	always_ff @(posedge clk) begin
		if (reset)
			w_cnt <= '0;
		else if (w_wr)
			w_cnt <= (w_cnt == W_AW'(W_DEPTH - 1)) ? '0 : w_cnt + 1'b1;
	end

	////////////////////
	// Stage 1
	////////////////////

	// Weight read and tap fields line up with the pixel read
	always_ff @(posedge clk) begin
		w_rd       <= wmem[taps.w_addr];
		d_last_tap <= taps.last_tap;
		d_first_ch <= taps.first_ch;
		d_last_ch  <= taps.last_ch;
		d_pos      <= taps.pos;
	end

	always_ff @(posedge clk) begin
		if (reset)
			d_valid <= 1'b0;
		else
			d_valid <= taps.valid;
	end

	////////////////////
	// Stage 2
	////////////////////

	assign prod = pxl_rd * w_rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			acc       <= '0;
			acc_clear <= 1'b1;
			conv.valid <= 1'b0;
		end else begin
			conv.valid <= d_valid && d_last_tap;
			if (d_valid) begin
				// Restart on tap 0 of every window
				acc       <= (acc_clear ? acc_t'(0) : acc) + acc_t'(prod);
				acc_clear <= d_last_tap;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (d_valid && d_last_tap) begin
			conv.first_ch <= d_first_ch;
			conv.last_ch  <= d_last_ch;
			conv.pos      <= d_pos;
		end
	end

	assign conv.sum = acc;

	// A full weight set must be loaded before the sweep starts
	assert property (@(posedge clk) disable iff (reset) taps.valid |-> (w_cnt == '0))
		else $error("weight counter not wrapped during computation");

	assert property (@(posedge clk) disable iff (reset) !(valid_weight_in && taps.valid))
		else $error("weight dropped while layer busy");

endmodule

`default_nettype wire

//--- logic/input_store.sv
`default_nettype none

module input_store #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            valid_in,
	input  conv_pkg::pixel_t pxl_in,
	output logic            image_loaded,
	output conv_pkg::pixel_t pxl_rd,
	tap_if.store            taps
);
	import conv_pkg::*;

	localparam int DEPTH  = CHANNEL_NUM_IN * IMAGE_HEIGHT * IMAGE_WIDTH;
	localparam int PXL_AW = $clog2(DEPTH);

	pixel_t            mem [DEPTH];
	logic [PXL_AW-1:0] wr_cnt;
	logic              wr_last;

	assign wr_last = (wr_cnt == PXL_AW'(DEPTH - 1));

	////////////////////
	// Write side
	////////////////////

	// Channel-major raster order maps straight onto the address
	always_ff @(posedge clk) begin
		if (valid_in)
			mem[wr_cnt] <= pxl_in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_cnt       <= '0;
			image_loaded <= 1'b0;
		end else begin
			image_loaded <= valid_in && wr_last;
			if (valid_in)
				wr_cnt <= wr_last ? '0 : wr_cnt + 1'b1;
		end
	end

	////////////////////
	// Read side
	////////////////////

	// Outside the image reads as zero
	always_ff @(posedge clk) begin
		if (taps.valid)
			pxl_rd <= taps.pad ? pixel_t'(0) : mem[taps.pxl_addr];
	end

endmodule

`default_nettype wire

//--- logic/layer_ctrl.sv
`default_nettype none

module layer_ctrl #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic image_loaded,
	output logic busy,
	tap_if.ctrl  taps
);
	import conv_pkg::*;

	localparam int PXL_AW = $clog2(CHANNEL_NUM_IN * IMAGE_HEIGHT * IMAGE_WIDTH);
	localparam int W_AW   = $clog2(CHANNEL_NUM_OUT * CHANNEL_NUM_IN * TAPS);
	localparam int POS_AW = $clog2(IMAGE_HEIGHT * IMAGE_WIDTH);
	localparam int OC_W   = $clog2(CHANNEL_NUM_OUT + 1);
	localparam int IC_W   = $clog2(CHANNEL_NUM_IN + 1);
	localparam int ROW_W  = $clog2(IMAGE_HEIGHT + 1);
	localparam int COL_W  = $clog2(IMAGE_WIDTH + 1);
	localparam int TAP_W  = $clog2(TAPS + 1);

	ctrl_state_t      state;
	logic [OC_W-1:0]  oc;
	logic [ROW_W-1:0] row;
	logic [COL_W-1:0] col;
	logic [IC_W-1:0]  ic;
	logic [TAP_W-1:0] tap;
	logic             drain_cnt;
	logic             tap_end, ic_end, col_end, row_end, oc_end;

	assign tap_end = (tap == TAP_W'(TAPS - 1));
	assign ic_end  = (ic == IC_W'(CHANNEL_NUM_IN - 1));
	assign col_end = (col == COL_W'(IMAGE_WIDTH - 1));
	assign row_end = (row == ROW_W'(IMAGE_HEIGHT - 1));
	assign oc_end  = (oc == OC_W'(CHANNEL_NUM_OUT - 1));

	assign busy = (state != st_idle);

	////////////////////
	// Tap decode
	////////////////////

	always_comb begin
		int rr;
		int cc;
		// Window offsets run from -1 to +1 around the output position
		rr = int'(row) + int'(tap) / 3 - 1;
		cc = int'(col) + int'(tap) % 3 - 1;
		taps.valid    = (state == st_compute);
		taps.pad      = (rr < 0) || (rr >= IMAGE_HEIGHT) || (cc < 0) || (cc >= IMAGE_WIDTH);
		taps.pxl_addr = taps.pad ? '0 :
			PXL_AW'((int'(ic) * IMAGE_HEIGHT + rr) * IMAGE_WIDTH + cc);
		taps.w_addr   = W_AW'((int'(oc) * CHANNEL_NUM_IN + int'(ic)) * TAPS + int'(tap));
		taps.pos      = POS_AW'(int'(row) * IMAGE_WIDTH + int'(col));
		taps.last_tap = tap_end;
		taps.first_ch = (ic == '0);
		taps.last_ch  = ic_end;
	end

	////////////////////
	// Sweep FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			oc        <= '0;
			row       <= '0;
			col       <= '0;
			ic        <= '0;
			tap       <= '0;
			drain_cnt <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (image_loaded)
						state <= st_compute;
				end
				st_compute: begin
					// Nested loops, tap innermost
					if (!tap_end) begin
						tap <= tap + 1'b1;
					end else begin
						tap <= '0;
						if (!ic_end) begin
							ic <= ic + 1'b1;
						end else begin
							ic <= '0;
							if (!col_end) begin
								col <= col + 1'b1;
							end else begin
								col <= '0;
								if (!row_end) begin
									row <= row + 1'b1;
								end else begin
									row <= '0;
									if (!oc_end) begin
										oc <= oc + 1'b1;
									end else begin
										oc    <= '0;
										state <= st_drain;
									end
								end
							end
						end
					end
				end
				st_drain: begin
					// Two cycles for the MAC pipe, done covers the last result
					drain_cnt <= !drain_cnt;
					if (drain_cnt)
						state <= st_done;
				end
				st_done: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// A new image must not land on a sweep in progress
	assert property (@(posedge clk) disable iff (reset) image_loaded |-> !busy)
		else $error("image_loaded while layer busy");

endmodule

`default_nettype wire

//--- logic/conv_ifs.sv
`default_nettype none

// One tap request per cycle, from the sweep controller
interface tap_if #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
);
	import conv_pkg::*;

	localparam int PXL_AW = $clog2(CHANNEL_NUM_IN * IMAGE_HEIGHT * IMAGE_WIDTH);
	localparam int W_AW   = $clog2(CHANNEL_NUM_OUT * CHANNEL_NUM_IN * TAPS);
	localparam int POS_AW = $clog2(IMAGE_HEIGHT * IMAGE_WIDTH);

	logic              valid;
	logic [PXL_AW-1:0] pxl_addr;
	logic              pad;
	logic [W_AW-1:0]   w_addr;
	logic              last_tap;
	logic              first_ch;
	logic              last_ch;
	logic [POS_AW-1:0] pos;

	modport ctrl  (output valid, pxl_addr, pad, w_addr, last_tap, first_ch, last_ch, pos);
	modport store (input valid, pxl_addr, pad);
	modport mac   (input valid, w_addr, last_tap, first_ch, last_ch, pos);
endinterface

// Finished 3x3 sum of one input channel at one output position
interface conv_if #(
	parameter int IMAGE_WIDTH     = 8,
	parameter int IMAGE_HEIGHT    = 8,
	parameter int CHANNEL_NUM_IN  = 4,
	parameter int CHANNEL_NUM_OUT = 4
);
	import conv_pkg::*;

	localparam int POS_AW = $clog2(IMAGE_HEIGHT * IMAGE_WIDTH);

	logic              valid;
	acc_t              sum;
	logic              first_ch;
	logic              last_ch;
	logic [POS_AW-1:0] pos;

	modport mac   (output valid, sum, first_ch, last_ch, pos);
	modport accum (input valid, sum, first_ch, last_ch, pos);
endinterface

`default_nettype wire

//--- logic/conv_pkg.sv
`default_nettype none

package conv_pkg;

	////////////////////
	// Arithmetic types
	////////////////////

	// Input pixel and kernel weight
	typedef logic signed [7:0] pixel_t;
	typedef logic signed [7:0] weight_t;

	// Full-precision product of one tap
	typedef logic signed [15:0] prod_t;

	// Accumulator and output value, room for 9 taps over 16 channels
	typedef logic signed [23:0] acc_t;

	// Kernel taps of a 3x3 window
	localparam int TAPS = 9;

	////////////////////
	// Control FSM
	////////////////////

	typedef enum logic [1:0] {
		st_idle,
		st_compute,
		st_drain,
		st_done
	} ctrl_state_t;

endpackage

`default_nettype wire
